// ==== mips_pkg.sv ====
`default_nettype none

package mips_pkg;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Field and word types
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	typedef logic [31:0] word_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [5:0]  opcode_t;
	typedef logic [5:0]  funct_t;
	typedef logic [4:0]  shamt_t;

	typedef enum logic [3:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_XOR,
		ALU_SLT,
		ALU_SLTU,
		ALU_SLL,
		ALU_SRL,
		ALU_LUI
	} alu_op_t;

	typedef enum logic [2:0] {
		PC_SEQ,
		PC_BEQ,
		PC_BNE,
		PC_JUMP,
		PC_REG   // JR
	} next_pc_t;

	typedef struct packed {
		alu_op_t  alu_op;
		next_pc_t next_pc;
		logic     reg_write;
		logic     reg_dst_rd;   // Write rd instead of rt
		logic     alu_src_imm;
		logic     mem_read;
		logic     mem_write;
		logic     mem_to_reg;
	} ctrl_t;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Encodings
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	localparam opcode_t OP_SPECIAL = 6'h00;
	localparam opcode_t OP_J       = 6'h02;
	localparam opcode_t OP_BEQ     = 6'h04;
	localparam opcode_t OP_BNE     = 6'h05;
	localparam opcode_t OP_ADDIU   = 6'h09;
	localparam opcode_t OP_SLTI    = 6'h0a;
	localparam opcode_t OP_ANDI    = 6'h0c;
	localparam opcode_t OP_ORI     = 6'h0d;
	localparam opcode_t OP_XORI    = 6'h0e;
	localparam opcode_t OP_LUI     = 6'h0f;
	localparam opcode_t OP_LW      = 6'h23;
	localparam opcode_t OP_SW      = 6'h2b;

	localparam funct_t FN_SLL  = 6'h00;
	localparam funct_t FN_SRL  = 6'h02;
	localparam funct_t FN_JR   = 6'h08;
	localparam funct_t FN_ADDU = 6'h21;
	localparam funct_t FN_SUBU = 6'h23;
	localparam funct_t FN_AND  = 6'h24;
	localparam funct_t FN_OR   = 6'h25;
	localparam funct_t FN_XOR  = 6'h26;
	localparam funct_t FN_SLT  = 6'h2a;
	localparam funct_t FN_SLTU = 6'h2b;

	localparam word_t HALT_ADDRESS = 32'h0000_0000;

endpackage

`default_nettype wire

// ==== mips_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_decoder (
	input  mips_pkg::word_t     instruction,
	output mips_pkg::ctrl_t     ctrl,
	output mips_pkg::reg_addr_t rs,
	output mips_pkg::reg_addr_t rt,
	output mips_pkg::reg_addr_t rd_dest,
	output mips_pkg::shamt_t    shamt,
	output mips_pkg::word_t     imm,
	output logic [25:0]         jump_index
);

	mips_pkg::opcode_t   opcode;
	mips_pkg::funct_t    funct;
	mips_pkg::reg_addr_t rd;
	logic                zero_ext;

	assign opcode     = instruction[31:26];
	assign rs         = instruction[25:21];
	assign rt         = instruction[20:16];
	assign rd         = instruction[15:11];
	assign shamt      = instruction[10:6];
	assign funct      = instruction[5:0];
	assign jump_index = instruction[25:0];

	assign imm     = zero_ext ? {16'h0000, instruction[15:0]}
	                          : {{16{instruction[15]}}, instruction[15:0]};
	assign rd_dest = ctrl.reg_dst_rd ? rd : rt;

	always_comb begin
		ctrl.alu_op      = mips_pkg::ALU_ADD;
		ctrl.next_pc     = mips_pkg::PC_SEQ;
		ctrl.reg_write   = 1'b0;   // Unknown encodings fall through as no-ops
		ctrl.reg_dst_rd  = 1'b0;
		ctrl.alu_src_imm = 1'b0;
		ctrl.mem_read    = 1'b0;
		ctrl.mem_write   = 1'b0;
		ctrl.mem_to_reg  = 1'b0;
		zero_ext         = 1'b0;

		case (opcode)
			mips_pkg::OP_SPECIAL: begin
				ctrl.reg_dst_rd = 1'b1;
				ctrl.reg_write  = 1'b1;
				case (funct)
					mips_pkg::FN_ADDU: ctrl.alu_op = mips_pkg::ALU_ADD;
					mips_pkg::FN_SUBU: ctrl.alu_op = mips_pkg::ALU_SUB;
					mips_pkg::FN_AND:  ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::FN_OR:   ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::FN_XOR:  ctrl.alu_op = mips_pkg::ALU_XOR;
					mips_pkg::FN_SLT:  ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::FN_SLTU: ctrl.alu_op = mips_pkg::ALU_SLTU;
					mips_pkg::FN_SLL:  ctrl.alu_op = mips_pkg::ALU_SLL;
					mips_pkg::FN_SRL:  ctrl.alu_op = mips_pkg::ALU_SRL;
					mips_pkg::FN_JR: begin
						ctrl.reg_write = 1'b0;
						ctrl.next_pc   = mips_pkg::PC_REG;
					end
					default: ctrl.reg_write = 1'b0;
				endcase
			end
			mips_pkg::OP_ADDIU, mips_pkg::OP_SLTI, mips_pkg::OP_LUI,
			mips_pkg::OP_ANDI, mips_pkg::OP_ORI, mips_pkg::OP_XORI: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				case (opcode)
					mips_pkg::OP_SLTI: ctrl.alu_op = mips_pkg::ALU_SLT;
					mips_pkg::OP_LUI:  ctrl.alu_op = mips_pkg::ALU_LUI;
					mips_pkg::OP_ANDI: ctrl.alu_op = mips_pkg::ALU_AND;
					mips_pkg::OP_ORI:  ctrl.alu_op = mips_pkg::ALU_OR;
					mips_pkg::OP_XORI: ctrl.alu_op = mips_pkg::ALU_XOR;
					default:           ctrl.alu_op = mips_pkg::ALU_ADD;
				endcase
				zero_ext = (opcode == mips_pkg::OP_ANDI) || (opcode == mips_pkg::OP_ORI) ||
				           (opcode == mips_pkg::OP_XORI);
			end
			mips_pkg::OP_LW: begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
			end
			mips_pkg::OP_SW: begin
				ctrl.alu_src_imm = 1'b1;
				ctrl.mem_write   = 1'b1;
			end
			mips_pkg::OP_BEQ: begin
				ctrl.alu_op  = mips_pkg::ALU_SUB;   // Zero flag means rs == rt
				ctrl.next_pc = mips_pkg::PC_BEQ;
			end
			mips_pkg::OP_BNE: begin
				ctrl.alu_op  = mips_pkg::ALU_SUB;
				ctrl.next_pc = mips_pkg::PC_BNE;
			end
			mips_pkg::OP_J: ctrl.next_pc = mips_pkg::PC_JUMP;
			default: ;
		endcase
	end

endmodule

`default_nettype wire

// ==== mips_alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_alu (
	input  mips_pkg::word_t   a,
	input  mips_pkg::word_t   b,
	input  mips_pkg::shamt_t  shamt,
	input  mips_pkg::alu_op_t op,
	output mips_pkg::word_t   result,
	output logic              zero
);

	logic signed_lt;
	logic unsigned_lt;

	assign signed_lt   = $signed(a) < $signed(b);
	assign unsigned_lt = a < b;

	always_comb begin
		case (op)
			mips_pkg::ALU_ADD: begin
				result = a + b;   // No overflow trap, ADDU semantics
			end
			mips_pkg::ALU_SUB: begin
				result = a - b;
			end
			mips_pkg::ALU_AND: begin
				result = a & b;
			end
			mips_pkg::ALU_OR: begin
				result = a | b;
			end
			mips_pkg::ALU_XOR: begin
				result = a ^ b;
			end
			mips_pkg::ALU_SLT: begin
				result = {31'd0, signed_lt};
			end
			mips_pkg::ALU_SLTU: begin
				result = {31'd0, unsigned_lt};
			end
			mips_pkg::ALU_SLL: begin
				result = b << shamt;   // Shifts act on rt
			end
			mips_pkg::ALU_SRL: begin
				result = b >> shamt;
			end
			mips_pkg::ALU_LUI: begin
				result = {b[15:0], 16'h0000};
			end
			default: begin
				result = '0;
			end
		endcase
	end

	// Branch compare
	assign zero = (result == '0);

endmodule

`default_nettype wire

// ==== mips_register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_register_file (
	input  logic                clk,
	input  logic                reset,
	input  logic                clk_enable,
	input  mips_pkg::reg_addr_t read_addr_a,
	input  mips_pkg::reg_addr_t read_addr_b,
	input  mips_pkg::reg_addr_t write_addr,
	input  mips_pkg::word_t     write_data,
	input  logic                write_enable,
	output mips_pkg::word_t     read_data_a,
	output mips_pkg::word_t     read_data_b,
	output mips_pkg::word_t     register_v0
);

	mips_pkg::word_t regs [32];

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Write port
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (!reset && clk_enable && write_enable && (write_addr != 5'd0)) begin
			regs[write_addr] <= write_data;
		end
	end

	// Asynchronous reads, $zero hardwired
	assign read_data_a = (read_addr_a == 5'd0) ? '0 : regs[read_addr_a];
	assign read_data_b = (read_addr_b == 5'd0) ? '0 : regs[read_addr_b];

	assign register_v0 = regs[2];

endmodule

`default_nettype wire

// ==== mips_pc.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_pc #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
	input  logic               clk,
	input  logic               reset,
	input  logic               clk_enable,
	input  mips_pkg::next_pc_t next_pc,
	input  logic               zero,
	input  mips_pkg::word_t    imm,
	input  logic [25:0]        jump_index,
	input  mips_pkg::word_t    reg_target,
	output mips_pkg::word_t    pc,
	output logic               active
);

	mips_pkg::word_t pc_plus4;
	mips_pkg::word_t branch_target;
	mips_pkg::word_t jump_target;
	mips_pkg::word_t pc_next;

	assign pc_plus4      = pc + 32'd4;
	assign branch_target = pc_plus4 + {imm[29:0], 2'b00};
	assign jump_target   = {pc_plus4[31:28], jump_index, 2'b00};

	always_comb begin
		case (next_pc)
			mips_pkg::PC_BEQ:  pc_next = zero ? branch_target : pc_plus4;
			mips_pkg::PC_BNE:  pc_next = zero ? pc_plus4 : branch_target;
			mips_pkg::PC_JUMP: pc_next = jump_target;
			mips_pkg::PC_REG:  pc_next = reg_target;
			default:           pc_next = pc_plus4;
		endcase
	end

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// PC register and halt tracking
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	always_ff @(posedge clk) begin
		if (reset) begin
			pc     <= RESET_VECTOR;
			active <= 1'b1;
		end else if (clk_enable && active) begin
			pc <= pc_next;
			if (pc_next == mips_pkg::HALT_ADDRESS) begin
				active <= 1'b0;   // Frozen from here on
			end
		end
	end

endmodule

`default_nettype wire

// ==== mips_cpu_harvard.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_harvard #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
	// Standard signals
	input  logic        clk,
	input  logic        reset,
	output logic        active,
	output logic [31:0] register_v0,

	// Global stall
	input  logic        clk_enable,

	// Instruction port, combinational read
	output logic [31:0] instr_address,
	input  logic [31:0] instr_readdata,

	// Data port, combinational read and single cycle write
	output logic [31:0] data_address,
	output logic        data_write,
	output logic        data_read,
	output logic [31:0] data_writedata,
	input  logic [31:0] data_readdata
);

	mips_pkg::ctrl_t     ctrl;
	mips_pkg::reg_addr_t rs;
	mips_pkg::reg_addr_t rt;
	mips_pkg::reg_addr_t rd_dest;
	mips_pkg::shamt_t    shamt;
	mips_pkg::word_t     imm;
	logic [25:0]         jump_index;

	mips_pkg::word_t reg_read_a;
	mips_pkg::word_t reg_read_b;
	mips_pkg::word_t alu_b;
	mips_pkg::word_t alu_result;
	mips_pkg::word_t writeback;
	logic            alu_zero;
	logic            running;
	logic            reg_write_en;

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Datapath muxes and strobe gating
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign running = active && !reset;

	assign alu_b     = ctrl.alu_src_imm ? imm : reg_read_b;
	assign writeback = ctrl.mem_to_reg ? data_readdata : alu_result;

	assign reg_write_en   = ctrl.reg_write && running;
	assign data_read      = ctrl.mem_read && running;
	assign data_write     = ctrl.mem_write && running;
	assign data_address   = alu_result;   // Base plus offset for LW/SW
	assign data_writedata = reg_read_b;

	mips_decoder u_decoder (
		.instruction (instr_readdata),
		.ctrl        (ctrl),
		.rs          (rs),
		.rt          (rt),
		.rd_dest     (rd_dest),
		.shamt       (shamt),
		.imm         (imm),
		.jump_index  (jump_index)
	);

	mips_register_file u_register_file (
		.clk          (clk),
		.reset        (reset),
		.clk_enable   (clk_enable),
		.read_addr_a  (rs),
		.read_addr_b  (rt),
		.write_addr   (rd_dest),
		.write_data   (writeback),
		.write_enable (reg_write_en),
		.read_data_a  (reg_read_a),
		.read_data_b  (reg_read_b),
		.register_v0  (register_v0)
	);

	mips_alu u_alu (
		.a      (reg_read_a),
		.b      (alu_b),
		.shamt  (shamt),
		.op     (ctrl.alu_op),
		.result (alu_result),
		.zero   (alu_zero)
	);

	mips_pc #(
		.RESET_VECTOR (RESET_VECTOR)
	) u_pc (
		.clk        (clk),
		.reset      (reset),
		.clk_enable (clk_enable),
		.next_pc    (ctrl.next_pc),
		.zero       (alu_zero),
		.imm        (imm),
		.jump_index (jump_index),
		.reg_target (reg_read_a),   // JR target
		.pc         (instr_address),
		.active     (active)
	);

endmodule

`default_nettype wire

// ==== mips_cpu_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module mips_cpu_assert #(
	parameter mips_pkg::word_t RESET_VECTOR = 32'hBFC0_0000
) (
	input logic        clk,
	input logic        reset,
	input logic        active,
	input logic [31:0] instr_address,
	input logic [31:0] register_v0,
	input logic        data_read,
	input logic        data_write
);

	// Never a read and a write in the same cycle
	assert property (@(posedge clk) !(data_read && data_write))
		else $error("data_read and data_write high together");

	assert property (@(posedge clk) disable iff (reset)
		!active |=> $stable(instr_address) && $stable(register_v0))
		else $error("PC or v0 changed while halted");

	assert property (@(posedge clk) (reset || !active) |-> !data_read && !data_write)
		else $error("Data strobe high in reset or halt");

	// First edge after reset release
	assert property (@(posedge clk) $fell(reset) |-> active && (instr_address == RESET_VECTOR))
		else $error("Core not at reset vector after reset");

endmodule

bind mips_cpu_harvard mips_cpu_assert #(.RESET_VECTOR(RESET_VECTOR)) u_assert (
	.clk           (clk),
	.reset         (reset),
	.active        (active),
	.instr_address (instr_address),
	.register_v0   (register_v0),
	.data_read     (data_read),
	.data_write    (data_write)
);

`default_nettype wire

// ==== tb_mips_cpu_harvard.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_mips_cpu_harvard;

	localparam int          CLK_PERIOD   = 4;
	localparam int          RESET_CYCLES = 16;
	localparam int          HOLD_CYCLES  = 6;
	localparam int          IMEM_WORDS   = 64;
	localparam int          DMEM_WORDS   = 16;
	localparam int          NUM_TESTS    = 6;
	localparam logic [31:0] RESET_VECTOR = 32'hBFC0_0000;
	localparam logic [31:0] NO_MEM       = 32'hFFFF_FFFF;

	typedef struct packed {
		logic [7:0]  start;
		logic [7:0]  len;
		logic [31:0] v0;
		logic [15:0] retired;
		logic [31:0] mem_addr;   // NO_MEM when the program never touches data memory
		logic [31:0] mem_data;
		logic        stall;
	} test_t;

	logic        clk;
	logic        reset;
	logic        clk_enable;
	logic        active;
	logic [31:0] register_v0;
	logic [31:0] instr_address;
	logic [31:0] instr_readdata;
	logic [31:0] data_address;
	logic        data_write;
	logic        data_read;
	logic [31:0] data_writedata;
	logic [31:0] data_readdata;

	logic [31:0] imem [0:IMEM_WORDS-1];
	logic [31:0] dmem [0:DMEM_WORDS-1];
	logic [31:0] prog_store [0:IMEM_WORDS-1];
	logic [31:0] imem_index;
	test_t       tests [0:NUM_TESTS-1];
	logic        table_ready = 1'b0;
	logic        stall_mode = 1'b0;
	integer      seed = 62;

	mips_cpu_harvard dut (
		.clk            (clk),
		.reset          (reset),
		.active         (active),
		.register_v0    (register_v0),
		.clk_enable     (clk_enable),
		.instr_address  (instr_address),
		.instr_readdata (instr_readdata),
		.data_address   (data_address),
		.data_write     (data_write),
		.data_read      (data_read),
		.data_writedata (data_writedata),
		.data_readdata  (data_readdata)
	);

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Memory models
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	assign imem_index     = (instr_address - RESET_VECTOR) >> 2;
	assign instr_readdata = (imem_index < IMEM_WORDS) ? imem[imem_index[5:0]] : 32'h0;
	assign data_readdata  = data_read ? dmem[data_address[5:2]] : 32'hDEAD_BEEF;

	always @(posedge clk) begin
		if (data_write && clk_enable) begin
			dmem[data_address[5:2]] <= data_writedata;
		end
	end

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	// Roughly three enabled edges in four while stalling
	always @(posedge clk) begin
		if (stall_mode) begin
			clk_enable <= ($random(seed) & 3) != 0;
		end else begin
			clk_enable <= 1'b1;
		end
	end

	function automatic logic [31:0] rtype_word(input logic [5:0] funct, input logic [4:0] rs,
			input logic [4:0] rt, input logic [4:0] rd, input logic [4:0] shamt);
		return {6'h00, rs, rt, rd, shamt, funct};
	endfunction

	function automatic logic [31:0] itype_word(input logic [5:0] op, input logic [4:0] rs,
			input logic [4:0] rt, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	function automatic logic [31:0] jump_word(input logic [31:0] target);
		return {6'h02, target[27:2]};
	endfunction

	task automatic compare_word(input logic [31:0] got, input logic [31:0] expected,
			input string what);
		if (got !== expected) begin
			$display("ERR @ %0t ns: %s is %h, expected %h", $time, what, got, expected);
			$display("** FAIL **");
			$fatal(1, "mismatch");
		end
	endtask

	// Holds reset for 16 edges, loads the program and checks the reset state
	task automatic reset_and_load(input test_t t);
		int i;
		@(posedge clk);
		reset <= 1'b1;
		@(negedge clk);
		for (i = 0; i < IMEM_WORDS; i++) begin
			imem[i] = (i < t.len) ? prog_store[t.start + i] : 32'h0;
		end
		for (i = 0; i < DMEM_WORDS; i++) begin
			dmem[i] <= 32'h0;
		end
		repeat (RESET_CYCLES - 1) @(posedge clk);
		@(negedge clk);
		compare_word({31'd0, active}, 32'd1, "active in reset");
		compare_word(instr_address, RESET_VECTOR, "instr_address in reset");
		compare_word({30'd0, data_read, data_write}, 32'd0, "data strobes in reset");
		@(posedge clk);
		reset <= 1'b0;
	endtask

	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	// Programs, table and run loop
	// ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
	initial begin
		int          n;
		int          retired;
		logic [31:0] v0_held;
		test_t       t;
		reset      = 1'b1;
		clk_enable = 1'b1;

		prog_store[0]  = itype_word(6'h09, 5'd0, 5'd8, 16'h7fff);      // ADDIU t0, zero, 0x7fff
		prog_store[1]  = itype_word(6'h09, 5'd0, 5'd9, 16'hfffe);      // ADDIU t1, zero, -2
		prog_store[2]  = itype_word(6'h0d, 5'd0, 5'd10, 16'hfffe);     // ORI t2, zero, 0xfffe
		prog_store[3]  = rtype_word(6'h26, 5'd9, 5'd10, 5'd11, 5'd0);  // XOR t3, t1, t2
		prog_store[4]  = itype_word(6'h0f, 5'd0, 5'd12, 16'h1234);     // LUI t4, 0x1234
		prog_store[5]  = rtype_word(6'h21, 5'd11, 5'd12, 5'd11, 5'd0); // ADDU t3, t3, t4
		prog_store[6]  = rtype_word(6'h23, 5'd11, 5'd8, 5'd11, 5'd0);  // SUBU t3, t3, t0
		prog_store[7]  = rtype_word(6'h00, 5'd0, 5'd8, 5'd12, 5'd4);   // SLL t4, t0, 4
		prog_store[8]  = rtype_word(6'h24, 5'd11, 5'd12, 5'd2, 5'd0);  // AND v0, t3, t4
		prog_store[9]  = rtype_word(6'h02, 5'd0, 5'd9, 5'd13, 5'd28);  // SRL t5, t1, 28
		prog_store[10] = rtype_word(6'h25, 5'd2, 5'd13, 5'd2, 5'd0);   // OR v0, v0, t5
		prog_store[11] = rtype_word(6'h2a, 5'd9, 5'd8, 5'd13, 5'd0);   // SLT t5, t1, t0
		prog_store[12] = rtype_word(6'h21, 5'd2, 5'd13, 5'd2, 5'd0);   // ADDU v0, v0, t5
		prog_store[13] = rtype_word(6'h2b, 5'd9, 5'd8, 5'd13, 5'd0);   // SLTU t5, t1, t0
		prog_store[14] = rtype_word(6'h21, 5'd2, 5'd13, 5'd2, 5'd0);   // ADDU v0, v0, t5
		prog_store[15] = itype_word(6'h0a, 5'd9, 5'd13, 16'hfffd);     // SLTI t5, t1, -3
		prog_store[16] = rtype_word(6'h21, 5'd2, 5'd13, 5'd2, 5'd0);   // ADDU v0, v0, t5
		prog_store[17] = itype_word(6'h0c, 5'd9, 5'd13, 16'hf0f0);     // ANDI t5, t1, 0xf0f0
		prog_store[18] = rtype_word(6'h26, 5'd2, 5'd13, 5'd2, 5'd0);   // XOR v0, v0, t5
		prog_store[19] = itype_word(6'h0e, 5'd2, 5'd2, 16'h8001);      // XORI v0, v0, 0x8001
		prog_store[20] = rtype_word(6'h08, 5'd0, 5'd0, 5'd0, 5'd0);    // JR zero
		prog_store[21] = itype_word(6'h23, 5'd0, 5'd8, 16'h0018);      // LW t0, 0x18(zero)
		prog_store[22] = itype_word(6'h09, 5'd0, 5'd8, 16'h0010);      // ADDIU t0, zero, 0x10
		prog_store[23] = itype_word(6'h0f, 5'd0, 5'd9, 16'hcafe);      // LUI t1, 0xcafe
		prog_store[24] = itype_word(6'h0d, 5'd9, 5'd9, 16'hbabe);      // ORI t1, t1, 0xbabe
		prog_store[25] = itype_word(6'h2b, 5'd8, 5'd9, 16'h0008);      // SW t1, 8(t0)
		prog_store[26] = itype_word(6'h09, 5'd0, 5'd10, 16'h0020);     // ADDIU t2, zero, 0x20
		prog_store[27] = itype_word(6'h23, 5'd10, 5'd2, 16'hfff8);     // LW v0, -8(t2)
		prog_store[28] = rtype_word(6'h08, 5'd0, 5'd0, 5'd0, 5'd0);    // JR zero
		prog_store[29] = itype_word(6'h09, 5'd0, 5'd8, 16'h0005);      // ADDIU t0, zero, 5
		prog_store[30] = itype_word(6'h09, 5'd0, 5'd9, 16'h0005);      // ADDIU t1, zero, 5
		prog_store[31] = itype_word(6'h09, 5'd0, 5'd2, 16'h0001);      // ADDIU v0, zero, 1
		prog_store[32] = itype_word(6'h05, 5'd8, 5'd9, 16'h0001);      // BNE not taken
		prog_store[33] = itype_word(6'h09, 5'd2, 5'd2, 16'h0002);      // ADDIU v0, v0, 2
		prog_store[34] = itype_word(6'h04, 5'd8, 5'd9, 16'h0001);      // BEQ taken
		prog_store[35] = itype_word(6'h09, 5'd2, 5'd2, 16'h0100);      // Skipped
		prog_store[36] = itype_word(6'h09, 5'd0, 5'd9, 16'h0006);      // ADDIU t1, zero, 6
		prog_store[37] = itype_word(6'h04, 5'd8, 5'd9, 16'h0001);      // BEQ not taken
		prog_store[38] = itype_word(6'h05, 5'd8, 5'd9, 16'h0001);      // BNE taken
		prog_store[39] = itype_word(6'h09, 5'd2, 5'd2, 16'h0200);      // Skipped
		prog_store[40] = jump_word(RESET_VECTOR + 32'd52);             // J to word 13
		prog_store[41] = itype_word(6'h09, 5'd2, 5'd2, 16'h0400);      // Skipped
		prog_store[42] = itype_word(6'h09, 5'd2, 5'd2, 16'h0008);      // ADDIU v0, v0, 8
		prog_store[43] = rtype_word(6'h08, 5'd0, 5'd0, 5'd0, 5'd0);    // JR zero

		// Start, length, v0, retired, data address, data word, stall
		tests[0] = '{8'd0, 8'd21, 32'h0002_F0E1, 16'd21, NO_MEM, 32'h0, 1'b0};
		tests[1] = '{8'd21, 8'd8, 32'hCAFE_BABE, 16'd8, 32'h18, 32'hCAFE_BABE, 1'b0};
		tests[2] = '{8'd29, 8'd15, 32'h0000_000B, 16'd12, NO_MEM, 32'h0, 1'b0};
		for (n = 0; n < 3; n++) begin
			tests[n + 3]       = tests[n];
			tests[n + 3].stall = 1'b1;
		end
		table_ready = 1'b1;

		for (n = 0; n < NUM_TESTS; n++) begin
			t          = tests[n];
			stall_mode = t.stall;
			reset_and_load(t);
			retired = 0;
			while (active) begin
				@(negedge clk);
				if (data_read || data_write) begin
					compare_word(data_address, t.mem_addr, "data_address");
				end
				if (active && clk_enable) begin
					retired++;   // Next rising edge retires one
				end
			end
			compare_word(register_v0, t.v0, "register_v0");
			compare_word(retired, 32'(t.retired), "retired count");
			if (t.mem_addr != NO_MEM) begin
				compare_word(dmem[t.mem_addr[5:2]], t.mem_data, "data memory word");
			end
			v0_held = register_v0;
			repeat (HOLD_CYCLES) begin
				@(negedge clk);
				compare_word({31'd0, active}, 32'd0, "active after halt");
				compare_word(instr_address, 32'h0, "instr_address after halt");
				compare_word(register_v0, v0_held, "register_v0 after halt");
			end
		end
		$display("** PASS **");
		$finish;
	end

	// Watchdog
	initial begin
		int limit;
		int k;
		limit = 0;
		wait (table_ready);
		for (k = 0; k < NUM_TESTS; k++) begin
			limit += tests[k].retired * 4 + RESET_CYCLES + HOLD_CYCLES + 4;
		end
		#(limit * CLK_PERIOD);
		$display("Timeout: the programs did not finish within %0d clock cycles", limit);
		$display("** FAIL **");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// ==== files.f ====
mips_pkg.sv
mips_decoder.sv
mips_alu.sv
mips_register_file.sv
mips_pc.sv
mips_cpu_harvard.sv
mips_cpu_assert.sv
tb_mips_cpu_harvard.sv

// ==== Bender.yml ====
package:
  name: mips_cpu_harvard

sources:
  - files:
      - mips_pkg.sv
      - mips_decoder.sv
      - mips_alu.sv
      - mips_register_file.sv
      - mips_pc.sv
      - mips_cpu_harvard.sv
  - target: test
    files:
      - mips_cpu_assert.sv
      - tb_mips_cpu_harvard.sv
